// ==== logic/lsq_macros.svh ====
////////////////////////////////////////////////////////////
// LSQ sizing and memory opcode values
// Queue depths, register file and reorder buffer sizes
////////////////////////////////////////////////////////////
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// Sizes
`define LSQ_LQ_SIZE		8	// Load slots
`define LSQ_SQ_SIZE		8	// Store entries
`define LSQ_PRF_SIZE	64	// Physical registers
`define LSQ_ROB_SIZE	32	// Reorder entries
`define LSQ_MEM_TAGS	16	// Memory tags with tag 0 unused

// Memory opcodes
`define LSQ_OP_LDQ		6'h29
`define LSQ_OP_LDQ_L	6'h2b	// Load locked
`define LSQ_OP_STQ		6'h2d
`define LSQ_OP_STQ_C	6'h2f	// Store conditional

`endif

// ==== logic/lsq_pkg.sv ====
////////////////////////////////////////////////////////////
// LSQ types
// Queue indices, dispatched instructions, CDB and results
////////////////////////////////////////////////////////////
`include "lsq_macros.svh"

package lsq_pkg;
	typedef logic [63:0] data_t;
	typedef logic [$clog2(`LSQ_PRF_SIZE)-1:0] prf_tag_t;
	typedef logic [$clog2(`LSQ_ROB_SIZE)-1:0] rob_idx_t;
	typedef logic [$clog2(`LSQ_LQ_SIZE)-1:0] lq_idx_t;
	typedef logic [$clog2(`LSQ_SQ_SIZE)-1:0] sq_idx_t;
	typedef logic [5:0] op_t;

	typedef enum logic [1:0] {MEM_OP_NONE, MEM_OP_LOAD, MEM_OP_STORE} mem_op_e;

	typedef struct packed {
		logic valid;
		op_t op;
		data_t opa;
		data_t opb;			// Holds a register tag while opb_ready is low
		logic opb_ready;
		data_t rega;		// Store data or its tag
		logic rega_ready;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		prf_tag_t tag;
		data_t data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		prf_tag_t dest_tag;
		data_t data;
		rob_idx_t rob_idx;
	} result_t;
endpackage

// ==== logic/lsq_mem_pkg.sv ====
////////////////////////////////////////////////////////////
// Memory port types
// Tags, bus commands and the request bundle
////////////////////////////////////////////////////////////
`include "lsq_macros.svh"

package lsq_mem_pkg;
	typedef logic [$clog2(`LSQ_MEM_TAGS)-1:0] mem_tag_t;	// Zero means no response

	typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_command_e;

	typedef struct packed {
		bus_command_e command;
		lsq_pkg::data_t addr;
		lsq_pkg::data_t data;
	} mem_req_t;

	// Port FSM
	typedef enum logic {PORT_IDLE, PORT_RETRY} port_state_e;
endpackage

// ==== logic/load_queue.sv ====
////////////////////////////////////////////////////////////
// Load queue
// Slots hold load operands, build the address and keep
// the value returned by memory until the slot is freed
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module load_queue (
	input clock,
	input reset,
	input lsq_pkg::dispatch_t dispatch,
	input alloc,
	input lsq_pkg::lq_idx_t alloc_idx,
	input lsq_pkg::cdb_t cdb_in,
	input issue,
	input lsq_pkg::lq_idx_t issue_idx,
	input [`LSQ_LQ_SIZE-1:0] fill,
	input lsq_pkg::data_t mem_data,
	input free,
	input lsq_pkg::lq_idx_t free_idx,
	input flush,
	output logic [`LSQ_LQ_SIZE-1:0] busy,
	output logic [`LSQ_LQ_SIZE-1:0] addr_ready,
	output logic [`LSQ_LQ_SIZE-1:0] requested,
	output logic [`LSQ_LQ_SIZE-1:0] value_valid,
	output lsq_pkg::data_t [`LSQ_LQ_SIZE-1:0] addr,
	output lsq_pkg::rob_idx_t [`LSQ_LQ_SIZE-1:0] rob_idx,
	output lsq_pkg::prf_tag_t [`LSQ_LQ_SIZE-1:0] dest_tag,
	output lsq_pkg::data_t [`LSQ_LQ_SIZE-1:0] value
);
	import lsq_pkg::*;

	data_t [`LSQ_LQ_SIZE-1:0] opa;
	data_t [`LSQ_LQ_SIZE-1:0] opb;
	logic [`LSQ_LQ_SIZE-1:0] opb_ready;
	logic [`LSQ_LQ_SIZE-1:0] cdb_hit;	// Slot waiting on the tag now on the CDB
	logic [`LSQ_LQ_SIZE-1:0] fill_ok;
	logic dispatch_hit;

	// Operand bypass in the dispatch cycle
	assign dispatch_hit = cdb_in.valid && !dispatch.opb_ready
		&& cdb_in.tag == prf_tag_t'(dispatch.opb);

	always_comb begin
		for (int i = 0; i < `LSQ_LQ_SIZE; i++) begin
			cdb_hit[i] = busy[i] && !opb_ready[i] && cdb_in.valid
				&& cdb_in.tag == prf_tag_t'(opb[i]);
			// Only an issued slot without a value takes returned data
			fill_ok[i] = fill[i] && busy[i] && requested[i] && !value_valid[i];
			addr[i] = opa[i] + opb[i];
		end
	end

	assign addr_ready = busy & opb_ready;

	////////////////////////////////////////////////////////////
	// Slot state
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			busy <= '0;
			opb_ready <= '0;
			requested <= '0;
			value_valid <= '0;
		end else begin
			opb_ready <= opb_ready | cdb_hit;
			value_valid <= value_valid | fill_ok;
			if (alloc) begin
				busy[alloc_idx] <= 1'b1;
				opb_ready[alloc_idx] <= dispatch.opb_ready || dispatch_hit;
				requested[alloc_idx] <= 1'b0;
				value_valid[alloc_idx] <= 1'b0;
			end
			if (issue)
				requested[issue_idx] <= 1'b1;
			if (free) begin
				busy[free_idx] <= 1'b0;
				requested[free_idx] <= 1'b0;
				value_valid[free_idx] <= 1'b0;
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < `LSQ_LQ_SIZE; i++) begin
			if (cdb_hit[i])
				opb[i] <= cdb_in.data;
			if (fill_ok[i])
				value[i] <= mem_data;
		end
		if (alloc) begin
			opa[alloc_idx] <= dispatch.opa;
			opb[alloc_idx] <= dispatch_hit ? cdb_in.data : dispatch.opb;
			rob_idx[alloc_idx] <= dispatch.rob_idx;
			dest_tag[alloc_idx] <= dispatch.dest_tag;
		end
	end
endmodule

// ==== logic/store_queue.sv ====
////////////////////////////////////////////////////////////
// Store queue
// Circular buffer filled at the tail, drained at the head
// in program order, shows only its head entry
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module store_queue (
	input clock,
	input reset,
	input lsq_pkg::dispatch_t dispatch,
	input alloc,
	input lsq_pkg::cdb_t cdb_in,
	input issue,
	input retire,
	input flush,
	output logic empty,
	output logic full,
	output logic head_ready,
	output logic head_requested,
	output lsq_pkg::data_t head_addr,
	output lsq_pkg::data_t head_data,
	output lsq_pkg::rob_idx_t head_rob_idx,
	output lsq_pkg::prf_tag_t head_dest_tag
);
	import lsq_pkg::*;

	logic [`LSQ_SQ_SIZE-1:0] busy;
	logic [`LSQ_SQ_SIZE-1:0] requested;
	logic [`LSQ_SQ_SIZE-1:0] opb_ready;
	logic [`LSQ_SQ_SIZE-1:0] data_ready;
	logic [`LSQ_SQ_SIZE-1:0] opb_hit;
	logic [`LSQ_SQ_SIZE-1:0] data_hit;
	data_t [`LSQ_SQ_SIZE-1:0] opa;
	data_t [`LSQ_SQ_SIZE-1:0] opb;
	data_t [`LSQ_SQ_SIZE-1:0] data;
	rob_idx_t [`LSQ_SQ_SIZE-1:0] rob_idx;
	prf_tag_t [`LSQ_SQ_SIZE-1:0] dest_tag;
	sq_idx_t head;
	sq_idx_t tail;
	logic opb_hit_now;
	logic data_hit_now;

	assign opb_hit_now = cdb_in.valid && !dispatch.opb_ready
		&& cdb_in.tag == prf_tag_t'(dispatch.opb);
	assign data_hit_now = cdb_in.valid && !dispatch.rega_ready
		&& cdb_in.tag == prf_tag_t'(dispatch.rega);

	always_comb begin
		for (int i = 0; i < `LSQ_SQ_SIZE; i++) begin
			opb_hit[i] = busy[i] && !opb_ready[i] && cdb_in.valid
				&& cdb_in.tag == prf_tag_t'(opb[i]);
			data_hit[i] = busy[i] && !data_ready[i] && cdb_in.valid
				&& cdb_in.tag == prf_tag_t'(data[i]);
		end
	end

	// Entries are contiguous from the head
	assign empty = !busy[head];
	assign full = busy[tail];
	assign head_ready = busy[head] && opb_ready[head] && data_ready[head];
	assign head_requested = busy[head] && requested[head];
	assign head_addr = opa[head] + opb[head];
	assign head_data = data[head];
	assign head_rob_idx = rob_idx[head];
	assign head_dest_tag = dest_tag[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			busy <= '0;
			requested <= '0;
			opb_ready <= '0;
			data_ready <= '0;
		end else if (flush) begin
			tail <= head;	// Head stays, every entry goes
			busy <= '0;
			requested <= '0;
		end else begin
			opb_ready <= opb_ready | opb_hit;
			data_ready <= data_ready | data_hit;
			if (alloc) begin
				busy[tail] <= 1'b1;
				requested[tail] <= 1'b0;
				opb_ready[tail] <= dispatch.opb_ready || opb_hit_now;
				data_ready[tail] <= dispatch.rega_ready || data_hit_now;
				tail <= tail + 1'b1;
			end
			if (issue)
				requested[head] <= 1'b1;
			if (retire) begin
				busy[head] <= 1'b0;
				requested[head] <= 1'b0;
				head <= head + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `LSQ_SQ_SIZE; i++) begin
			if (opb_hit[i])
				opb[i] <= cdb_in.data;
			if (data_hit[i])
				data[i] <= cdb_in.data;
		end
		if (alloc) begin
			opa[tail] <= dispatch.opa;
			opb[tail] <= opb_hit_now ? cdb_in.data : dispatch.opb;
			data[tail] <= data_hit_now ? cdb_in.data : dispatch.rega;
			rob_idx[tail] <= dispatch.rob_idx;
			dest_tag[tail] <= dispatch.dest_tag;
		end
	end
endmodule

// ==== logic/mem_tag_table.sv ====
////////////////////////////////////////////////////////////
// Memory tag table
// Maps each outstanding memory tag to its load slot
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module mem_tag_table (
	input clock,
	input reset,
	input record,
	input lsq_mem_pkg::mem_tag_t record_tag,
	input lsq_pkg::lq_idx_t record_idx,
	input lsq_mem_pkg::mem_tag_t mem_tag,
	output logic [`LSQ_LQ_SIZE-1:0] fill
);
	import lsq_pkg::*;

	logic [`LSQ_MEM_TAGS-1:0] tag_valid;
	lq_idx_t slot [`LSQ_MEM_TAGS];
	logic hit;

	assign hit = mem_tag != '0 && tag_valid[mem_tag];

	// One-hot fill toward the load queue
	always_comb begin
		fill = '0;
		if (hit)
			fill[slot[mem_tag]] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tag_valid <= '0;
		end else begin
			if (hit)
				tag_valid[mem_tag] <= 1'b0;
			if (record)
				tag_valid[record_tag] <= 1'b1;	// New acceptance wins
		end
	end

	always_ff @(posedge clock) begin
		if (record)
			slot[record_tag] <= record_idx;
	end
endmodule

// ==== logic/lsq_control.sv ====
////////////////////////////////////////////////////////////
// LSQ control
// Decode and allocation, memory port FSM with retry,
// result bus arbitration, full flag and flush
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_control (
	input clock,
	input reset,
	input lsq_pkg::dispatch_t dispatch,
	input lsq_pkg::rob_idx_t retire_head,
	input mispredict,
	input lsq_mem_pkg::mem_tag_t mem_response,
	input [`LSQ_LQ_SIZE-1:0] lq_busy,
	input [`LSQ_LQ_SIZE-1:0] lq_addr_ready,
	input [`LSQ_LQ_SIZE-1:0] lq_requested,
	input [`LSQ_LQ_SIZE-1:0] lq_value_valid,
	input lsq_pkg::data_t [`LSQ_LQ_SIZE-1:0] lq_addr,
	input lsq_pkg::rob_idx_t [`LSQ_LQ_SIZE-1:0] lq_rob_idx,
	input lsq_pkg::prf_tag_t [`LSQ_LQ_SIZE-1:0] lq_dest_tag,
	input lsq_pkg::data_t [`LSQ_LQ_SIZE-1:0] lq_value,
	input sq_empty,
	input sq_full,
	input sq_head_ready,
	input sq_head_requested,
	input lsq_pkg::data_t sq_head_addr,
	input lsq_pkg::data_t sq_head_data,
	input lsq_pkg::rob_idx_t sq_head_rob_idx,
	input lsq_pkg::prf_tag_t sq_head_dest_tag,
	output logic lq_alloc,
	output lsq_pkg::lq_idx_t lq_alloc_idx,
	output logic sq_alloc,
	output logic lq_issue,
	output lsq_pkg::lq_idx_t lq_issue_idx,
	output logic sq_issue,
	output logic lq_free,
	output lsq_pkg::lq_idx_t lq_free_idx,
	output logic sq_retire,
	output logic flush,
	output logic record,
	output lsq_pkg::lq_idx_t record_idx,
	output lsq_mem_pkg::mem_req_t mem_req,
	output lsq_pkg::result_t result,
	output logic lsq_full
);
	import lsq_pkg::*;
	import lsq_mem_pkg::*;

	mem_op_e dispatch_op;
	port_state_e state;
	mem_req_t retry_req;		// Refused request held for the retry
	lq_idx_t retry_idx;
	lq_idx_t req_idx;
	rob_idx_t store_age;
	logic accepted;

	always_comb begin
		case (dispatch.op)
			`LSQ_OP_LDQ, `LSQ_OP_LDQ_L: dispatch_op = MEM_OP_LOAD;
			`LSQ_OP_STQ, `LSQ_OP_STQ_C: dispatch_op = MEM_OP_STORE;
			default: dispatch_op = MEM_OP_NONE;
		endcase
	end

	assign flush = mispredict;
	assign lq_alloc = dispatch.valid && dispatch_op == MEM_OP_LOAD && !mispredict;
	assign sq_alloc = dispatch.valid && dispatch_op == MEM_OP_STORE && !mispredict;
	assign lsq_full = (&lq_busy) || sq_full;

	// Lowest free load slot
	always_comb begin
		lq_alloc_idx = '0;
		for (int i = `LSQ_LQ_SIZE - 1; i >= 0; i--) begin
			if (!lq_busy[i])
				lq_alloc_idx = lq_idx_t'(i);
		end
	end

	////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////
	assign store_age = sq_head_rob_idx - retire_head;	// Age from the retire head

	always_comb begin
		mem_req = '{command: BUS_NONE, addr: '0, data: '0};
		req_idx = '0;
		if (state == PORT_RETRY) begin
			mem_req = retry_req;
			req_idx = retry_idx;
		end else if (sq_head_ready && !sq_head_requested && sq_head_rob_idx == retire_head) begin
			mem_req = '{command: BUS_STORE, addr: sq_head_addr, data: sq_head_data};
		end else begin
			for (int i = `LSQ_LQ_SIZE - 1; i >= 0; i--) begin
				if (lq_addr_ready[i] && !lq_requested[i] && (sq_empty
						|| rob_idx_t'(lq_rob_idx[i] - retire_head) < store_age)) begin
					mem_req = '{command: BUS_LOAD, addr: lq_addr[i], data: '0};
					req_idx = lq_idx_t'(i);
				end
			end
		end
	end

	assign accepted = mem_req.command != BUS_NONE && mem_response != '0;
	assign lq_issue = accepted && mem_req.command == BUS_LOAD;
	assign lq_issue_idx = req_idx;
	assign sq_issue = accepted && mem_req.command == BUS_STORE;
	assign record = lq_issue;
	assign record_idx = req_idx;

	always_ff @(posedge clock) begin
		if (reset || mispredict)
			state <= PORT_IDLE;
		else if (mem_req.command != BUS_NONE && !accepted)
			state <= PORT_RETRY;
		else
			state <= PORT_IDLE;
	end

	always_ff @(posedge clock) begin
		if (state == PORT_IDLE) begin
			retry_req <= mem_req;
			retry_idx <= req_idx;
		end
	end

	// Result bus with store completion first
	always_comb begin
		result = '0;
		sq_retire = 1'b0;
		lq_free = 1'b0;
		lq_free_idx = '0;
		if (sq_head_requested) begin
			result = '{valid: 1'b1, dest_tag: sq_head_dest_tag, data: sq_head_addr,
				rob_idx: sq_head_rob_idx};
			sq_retire = 1'b1;
		end else begin
			for (int i = `LSQ_LQ_SIZE - 1; i >= 0; i--) begin
				if (lq_value_valid[i]) begin
					result = '{valid: 1'b1, dest_tag: lq_dest_tag[i], data: lq_value[i],
						rob_idx: lq_rob_idx[i]};
					lq_free = 1'b1;
					lq_free_idx = lq_idx_t'(i);
				end
			end
		end
	end
endmodule

// ==== logic/lsq_unit.sv ====
////////////////////////////////////////////////////////////
// Load/store queue top level
// Load queue, store queue, tag table and control
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_unit (
	input clock,
	input reset,
	input lsq_pkg::dispatch_t dispatch,
	input lsq_pkg::cdb_t cdb_in,
	input lsq_pkg::rob_idx_t retire_head,
	input mispredict,
	input lsq_mem_pkg::mem_tag_t mem_response,
	input lsq_mem_pkg::mem_tag_t mem_tag,
	input lsq_pkg::data_t mem_data,
	output lsq_mem_pkg::mem_req_t mem_req,
	output lsq_pkg::result_t result,
	output logic lsq_full
);
	import lsq_pkg::*;

	// Load queue status
	logic [`LSQ_LQ_SIZE-1:0] lq_busy;
	logic [`LSQ_LQ_SIZE-1:0] lq_addr_ready;
	logic [`LSQ_LQ_SIZE-1:0] lq_requested;
	logic [`LSQ_LQ_SIZE-1:0] lq_value_valid;
	logic [`LSQ_LQ_SIZE-1:0] fill;
	data_t [`LSQ_LQ_SIZE-1:0] lq_addr;
	rob_idx_t [`LSQ_LQ_SIZE-1:0] lq_rob_idx;
	prf_tag_t [`LSQ_LQ_SIZE-1:0] lq_dest_tag;
	data_t [`LSQ_LQ_SIZE-1:0] lq_value;

	// Store queue head
	logic sq_empty;
	logic sq_full;
	logic sq_head_ready;
	logic sq_head_requested;
	data_t sq_head_addr;
	data_t sq_head_data;
	rob_idx_t sq_head_rob_idx;
	prf_tag_t sq_head_dest_tag;

	// Strobes from control
	logic lq_alloc;
	lq_idx_t lq_alloc_idx;
	logic sq_alloc;
	logic lq_issue;
	lq_idx_t lq_issue_idx;
	logic sq_issue;
	logic lq_free;
	lq_idx_t lq_free_idx;
	logic sq_retire;
	logic flush;
	logic record;
	lq_idx_t record_idx;

	load_queue lq0 (
		.*,
		.alloc(lq_alloc),
		.alloc_idx(lq_alloc_idx),
		.issue(lq_issue),
		.issue_idx(lq_issue_idx),
		.free(lq_free),
		.free_idx(lq_free_idx),
		.busy(lq_busy),
		.addr_ready(lq_addr_ready),
		.requested(lq_requested),
		.value_valid(lq_value_valid),
		.addr(lq_addr),
		.rob_idx(lq_rob_idx),
		.dest_tag(lq_dest_tag),
		.value(lq_value)
	);

	store_queue sq0 (
		.*,
		.alloc(sq_alloc),
		.issue(sq_issue),
		.retire(sq_retire),
		.empty(sq_empty),
		.full(sq_full),
		.head_ready(sq_head_ready),
		.head_requested(sq_head_requested),
		.head_addr(sq_head_addr),
		.head_data(sq_head_data),
		.head_rob_idx(sq_head_rob_idx),
		.head_dest_tag(sq_head_dest_tag)
	);

	mem_tag_table tags0 (
		.*,
		.record_tag(mem_response)	// Accepted tag of the load being issued
	);

	lsq_control ctrl0 (.*);
endmodule

// ==== testbench/lsq_unit_tb.sv ====
////////////////////////////////////////////////////////////
// LSQ testbench
// Memory model with random refusals, stimulus and expected
// results from the golden file
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_unit_tb;
	import lsq_pkg::*;
	import lsq_mem_pkg::*;

	localparam int MAX_INSTR = 32;
	localparam int MEM_WORDS = 32;

	logic clock;
	logic reset;
	dispatch_t dispatch;
	cdb_t cdb_in;
	rob_idx_t retire_head;
	logic mispredict;
	mem_tag_t mem_response;
	mem_tag_t mem_tag;
	data_t mem_data;
	mem_req_t mem_req;
	result_t result;
	logic lsq_full;

	logic [63:0] golden [0:511];
	data_t memory [MEM_WORDS];
	dispatch_t instr [MAX_INSTR];
	logic flushed [MAX_INSTR];
	int cdb_delay [MAX_INSTR];
	data_t late_value [MAX_INSTR];	// Value sent on the CDB for a missing operand
	data_t exp_addr [MAX_INSTR];
	data_t exp_data [MAX_INSTR];
	data_t exp_value [MAX_INSTR];
	logic live [MAX_INSTR];
	logic opb_wait [MAX_INSTR];
	logic rega_wait [MAX_INSTR];
	int cdb_due [MAX_INSTR];
	int tag_owner [64];
	int rob_owner [32];
	logic rob_done [32];
	logic tag_busy [16];			// Memory tags with data on the way
	int tag_due [16];
	data_t tag_data [16];
	int n_mem, n_instr, next_instr, outstanding;
	int cycle, limit, value_errors, other_errors, seed;
	logic want_dispatch, dispatched, flush_next, seen_full, refused;
	mem_req_t refused_req;

	lsq_unit dut0 (.*);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	function automatic logic is_load(input op_t op);
		return op == `LSQ_OP_LDQ || op == `LSQ_OP_LDQ_L;
	endfunction

	function automatic mem_tag_t free_tag();
		mem_tag_t t;
		t = '0;
		for (int k = 15; k >= 1; k--)
			if (!tag_busy[k])
				t = mem_tag_t'(k);
		return t;
	endfunction

	task automatic check_result(input result_t got, input data_t exp_d, input rob_idx_t exp_rob);
		if (got.data !== exp_d) begin
			value_errors++;
			$display("ERR result.data tag %h: got %h, expected %h", got.dest_tag, got.data, exp_d);
		end
		if (got.rob_idx !== exp_rob) begin
			value_errors++;
			$display("ERR result.rob_idx tag %h: got %h, expected %h", got.dest_tag, got.rob_idx,
				exp_rob);
		end
	endtask

	task automatic check_mem_req(input mem_req_t got, input bus_command_e exp_cmd,
			input data_t exp_a, input data_t exp_d);
		if (got.command !== exp_cmd) begin
			value_errors++;
			$display("ERR mem_req.command: got %h, expected %h", got.command, exp_cmd);
		end
		if (got.addr !== exp_a) begin
			value_errors++;
			$display("ERR mem_req.addr: got %h, expected %h", got.addr, exp_a);
		end
		if (got.data !== exp_d) begin
			value_errors++;
			$display("ERR mem_req.data: got %h, expected %h", got.data, exp_d);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Golden file
	////////////////////////////////////////////////////////////
	task automatic load_golden();
		int w;
		$readmemh("testbench/lsq_unit_golden.txt", golden);
		n_mem = int'(golden[0]);
		n_instr = int'(golden[1]);
		for (int i = 0; i < MEM_WORDS; i++)
			memory[i] = 64'hf000_0000_0000_0000 | data_t'(i * 8);	// Fill by byte address
		for (int i = 0; i < n_mem; i++)
			memory[i] = golden[2 + i];
		for (int i = 0; i < n_instr; i++) begin
			w = 2 + n_mem + 8 * i;
			instr[i] = '0;
			instr[i].valid = 1'b1;
			instr[i].op = op_t'(golden[w]);
			instr[i].opa = golden[w + 1];
			instr[i].opb = golden[w + 2];
			instr[i].opb_ready = golden[w + 3][0];
			instr[i].rega_ready = golden[w + 3][1];
			instr[i].rega = golden[w + 4];
			instr[i].rob_idx = rob_idx_t'(golden[w + 5]);
			instr[i].dest_tag = prf_tag_t'(golden[w + 6]);
			flushed[i] = golden[w + 3][2];
			cdb_delay[i] = int'(golden[w + 3][15:8]);
			late_value[i] = golden[w + 7];
			exp_addr[i] = instr[i].opa + (instr[i].opb_ready ? instr[i].opb : late_value[i]);
			exp_data[i] = instr[i].rega_ready ? instr[i].rega : late_value[i];
			exp_value[i] = golden[2 + n_mem + 8 * n_instr + i];
		end
		limit = 40 * n_instr + 100;
	endtask

	task automatic start_instr(input int i);
		dispatch = instr[i];
		live[i] = 1'b1;
		tag_owner[instr[i].dest_tag] = i;
		rob_owner[instr[i].rob_idx] = i;
		rob_done[instr[i].rob_idx] = 1'b0;
		opb_wait[i] = !flushed[i] && !instr[i].opb_ready;
		rega_wait[i] = !flushed[i] && !instr[i].rega_ready && !is_load(instr[i].op);
		cdb_due[i] = cycle + cdb_delay[i];
		if (!flushed[i])
			outstanding++;
	endtask

	task automatic watch_result();
		int i;
		if (result.valid) begin
			i = tag_owner[result.dest_tag];
			if (i < 0) begin
				other_errors++;
				$display("Result for dest_tag %h, which has no live instruction", result.dest_tag);
			end else begin
				check_result(result, exp_value[i], instr[i].rob_idx);
				live[i] = 1'b0;
				tag_owner[result.dest_tag] = -1;
				rob_done[instr[i].rob_idx] = 1'b1;
				outstanding--;
			end
		end
	endtask

	// Memory port checked and answered in the same cycle
	task automatic watch_mem_req();
		int i;
		logic match;
		mem_tag_t tag;
		if (refused) begin
			check_mem_req(mem_req, refused_req.command, refused_req.addr, refused_req.data);
		end else if (mem_req.command == BUS_STORE) begin
			i = rob_owner[retire_head];
			if (i < 0 || !live[i] || is_load(instr[i].op)) begin
				other_errors++;
				$display("Store issued while the retire head %h is not a waiting store", retire_head);
			end else
				check_mem_req(mem_req, BUS_STORE, exp_addr[i], exp_data[i]);
		end else if (mem_req.command == BUS_LOAD) begin
			match = 1'b0;
			for (int k = 0; k < n_instr; k++)
				if (live[k] && is_load(instr[k].op) && exp_addr[k] == mem_req.addr)
					match = 1'b1;
			if (!match) begin
				other_errors++;
				$display("Load request to %h matches no waiting load", mem_req.addr);
			end
		end
		refused = 1'b0;
		if (mem_req.command != BUS_NONE && !mispredict) begin
			tag = (($random(seed) & 3) != 0) ? free_tag() : mem_tag_t'(0);
			if (tag == '0) begin
				refused = 1'b1;
				refused_req = mem_req;
			end else if (mem_req.addr >= MEM_WORDS * 8 || mem_req.addr[2:0] != 3'b0) begin
				other_errors++;
				$display("Memory request to address %h outside the model", mem_req.addr);
			end else begin
				mem_response = tag;
				if (mem_req.command == BUS_STORE)
					memory[mem_req.addr[7:3]] = mem_req.data;
				else begin
					tag_busy[tag] = 1'b1;
					tag_due[tag] = cycle + 2 + ($random(seed) & 3);
					tag_data[tag] = memory[mem_req.addr[7:3]];
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// One clock cycle of stimulus and checks
	////////////////////////////////////////////////////////////
	task automatic step_cycle();
		int pick;
		int idx;
		@(posedge clock);
		#2;
		cycle++;
		mem_response = '0;
		mispredict = flush_next;
		if (flush_next) begin
			for (int i = 0; i < n_instr; i++)
				if (flushed[i] && live[i]) begin
					live[i] = 1'b0;
					tag_owner[instr[i].dest_tag] = -1;
				end
			refused = 1'b0;
		end
		flush_next = 1'b0;
		for (int k = 0; k < 32; k++)
			if (rob_done[retire_head]) begin
				rob_done[retire_head] = 1'b0;
				retire_head++;
			end
		pick = 0;
		for (int t = 15; t >= 1; t--)
			if (tag_busy[t] && tag_due[t] <= cycle)
				pick = t;
		mem_tag = mem_tag_t'(pick);
		mem_data = (pick != 0) ? tag_data[pick] : '0;
		if (pick != 0)
			tag_busy[pick] = 1'b0;
		dispatch = '0;
		dispatched = 1'b0;
		if (lsq_full)
			seen_full = 1'b1;
		if (want_dispatch && !lsq_full) begin
			start_instr(next_instr);
			dispatched = 1'b1;
		end
		cdb_in = '0;
		idx = -1;
		for (int i = MAX_INSTR - 1; i >= 0; i--)
			if ((opb_wait[i] || rega_wait[i]) && cdb_due[i] <= cycle)
				idx = i;
		if (idx >= 0) begin
			cdb_in.valid = 1'b1;
			cdb_in.data = late_value[idx];
			if (opb_wait[idx]) begin
				cdb_in.tag = prf_tag_t'(instr[idx].opb);
				opb_wait[idx] = 1'b0;
			end else begin
				cdb_in.tag = prf_tag_t'(instr[idx].rega);
				rega_wait[idx] = 1'b0;
			end
		end
		#1;
		watch_result();
		watch_mem_req();
	endtask

	task automatic report_counts();
		$display("Error count: %0d wrong values, %0d other failures", value_errors, other_errors);
	endtask

	// Watchdog
	initial begin
		wait (cycle > 0 && cycle >= limit);
		other_errors++;
		$display("Timeout: the run did not finish within %0d cycles", limit);
		report_counts();
		$display("Errors found");
		$finish;
	end

	initial begin
		reset = 1'b1;
		dispatch = '0;
		cdb_in = '0;
		retire_head = '0;
		mispredict = 1'b0;
		mem_response = '0;
		mem_tag = '0;
		mem_data = '0;
		seed = 32'h5a60_863c;
		cycle = 0;
		limit = 32'h7fff_ffff;
		value_errors = 0;
		other_errors = 0;
		outstanding = 0;
		want_dispatch = 1'b0;
		dispatched = 1'b0;
		flush_next = 1'b0;
		seen_full = 1'b0;
		refused = 1'b0;
		for (int i = 0; i < MAX_INSTR; i++) begin
			live[i] = 1'b0;
			opb_wait[i] = 1'b0;
			rega_wait[i] = 1'b0;
			rob_owner[i] = -1;
			rob_done[i] = 1'b0;
		end
		for (int i = 0; i < 64; i++)
			tag_owner[i] = -1;
		for (int i = 0; i < 16; i++)
			tag_busy[i] = 1'b0;
		load_golden();
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;
		#1;
		if (mem_req.command !== BUS_NONE || result.valid !== 1'b0 || lsq_full !== 1'b0) begin
			value_errors++;
			$display("ERR after reset: mem_req.command %h, result.valid %h, lsq_full %h",
				mem_req.command, result.valid, lsq_full);
		end
		for (int i = 0; i < n_instr; i++) begin
			// The flush clears every entry, so older work drains first
			if (flushed[i] && (i == 0 || !flushed[i - 1]))
				while (outstanding != 0)
					step_cycle();
			next_instr = i;
			want_dispatch = 1'b1;
			dispatched = 1'b0;
			while (!dispatched)
				step_cycle();
			want_dispatch = 1'b0;
			if (flushed[i] && (i == n_instr - 1 || !flushed[i + 1])) begin
				flush_next = 1'b1;
				step_cycle();
			end
		end
		while (outstanding != 0)
			step_cycle();
		repeat (10) step_cycle();	// No late results may follow
		if (lsq_full !== 1'b0) begin
			value_errors++;
			$display("ERR lsq_full at the end: got %h, expected %h", lsq_full, 1'b0);
		end
		if (!seen_full) begin
			other_errors++;
			$display("lsq_full never rose while loads were waiting");
		end
		report_counts();
		if (value_errors + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end
endmodule

// ==== lsq_unit.f ====
+incdir+logic
logic/lsq_pkg.sv
logic/lsq_mem_pkg.sv
logic/load_queue.sv
logic/store_queue.sv
logic/mem_tag_table.sv
logic/lsq_control.sv
logic/lsq_unit.sv
testbench/lsq_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = lsq_unit_tb
FILELIST = lsq_unit.f
BUILD = obj_dir
SIM = $(BUILD)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) logic/lsq_macros.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD)

// ==== testbench/lsq_unit_golden.txt ====
// Header: memory word count, instruction count, then initial memory words from address 0
// Instruction: op opa opb flags rega rob_idx dest_tag cdb_value, then one expected value each
// Flags: bit 0 opb ready, bit 1 rega ready, bit 2 flushed, bits 15:8 CDB delay in cycles
8 17
00000000a0000000 00000000a0000001 00000000a0000002 00000000a0000003
00000000a0000004 00000000a0000005 00000000a0000006 00000000a0000007
29 0 8 3 0 0 10 0
2b 10 8 3 0 1 11 0
29 20 0 3 0 2 12 0
2d 30 8 3 5555 3 13 0
29 38 0 3 0 4 14 0
29 0 21 502 0 5 15 10
2f 8 20 1 22 6 16 7777
29 28 0 3 0 7 17 0
29 0 23 302 0 8 18 30
2d 0 0 1e01 24 9 19 9999
29 0 0 3 0 a 1a 0
29 8 0 3 0 b 1b 0
29 10 0 3 0 c 1c 0
29 18 0 3 0 d 1d 0
29 20 0 3 0 e 1e 0
29 28 0 3 0 f 1f 0
29 30 0 3 0 10 20 0
29 38 0 3 0 11 21 0
29 0 25 6 0 12 22 0
2d 0 8 5 26 13 23 0
29 0 8 3 0 12 24 0
2d 10 0 3 abcd 13 25 0
29 8 8 3 0 14 26 0
a0000001 a0000003 a0000004 38 5555 a0000002 28 7777
a0000006 0 9999 a0000001 a0000002 a0000003 a0000004 7777
a0000006 5555 0 0 a0000001 10 abcd
